//--- common/scsi_sm_pkg.sv
`default_nettype none

package scsi_sm_pkg;

  // width of the state code, one bit per next-state flop
  localparam int unsigned state_w = 5;

  // bit 0 is set in every busy state, so the return-to-idle
  // terms can drive it through an inverted plane
  typedef enum logic [state_w-1:0] {
    s_idle     = 5'b00000,
    s_cpu_sel  = 5'b00011, // cpu access, chip select
    s_cpu_ack  = 5'b00101, // cpu access, dsack request
    s_cpu_wait = 5'b00111, // hold until host drops cpureq
    s_rd_scsi  = 5'b01001, // chip to fifo, dack/re
    s_rd_latch = 5'b01011, // chip to fifo, latch and count
    s_wr_scsi  = 5'b10001, // fifo to chip, dack/we
    s_wr_done  = 5'b10011  // fifo to chip, count
  } scsi_state_e;

  localparam scsi_state_e reset_state = s_idle;

  // width of the product-term bus between the two planes
  localparam int unsigned num_terms = 18;

  // product term positions on e_n
  localparam int unsigned t_idle_cpu     = 0;  // idle, cpureq
  localparam int unsigned t_idle_rd      = 1;  // idle, read dma allowed
  localparam int unsigned t_idle_wr      = 2;  // idle, write dma allowed
  localparam int unsigned t_sel_wr       = 3;  // select, cpu write
  localparam int unsigned t_sel_rd       = 4;  // select, cpu read
  localparam int unsigned t_ack_wr       = 5;
  localparam int unsigned t_ack_rd       = 6;
  localparam int unsigned t_wait_hold_wr = 7;  // wait, cpureq still up
  localparam int unsigned t_wait_hold_rd = 8;
  localparam int unsigned t_rd_scsi      = 9;
  localparam int unsigned t_rd_latch     = 10;
  localparam int unsigned t_rd_latch_b3  = 11; // last byte of word
  localparam int unsigned t_wr_scsi      = 12;
  localparam int unsigned t_wr_done      = 13;
  localparam int unsigned t_wr_done_b3   = 14; // last byte of word
  localparam int unsigned t_illegal      = 15; // any unlisted code
  localparam int unsigned t_idle_stay    = 16; // idle, nothing to do
  localparam int unsigned t_wait_end     = 17; // wait, cpureq gone

endpackage

`default_nettype wire

//--- scsi_sm/scsi_sm_state.sv
`timescale 1ns/100ps
`default_nettype none

module scsi_sm_state (
  input  logic                               clk,
  input  logic                               arst_n,
  input  logic                               dreq,       // async, from the chip
  input  logic [scsi_sm_pkg::state_w-1:0]    next_state,
  output scsi_sm_pkg::scsi_state_e           state,
  output logic                               dreq_sync
);

  logic dreq_meta; // first synchronizer stage

  // two-flop synchronizer for dreq
  // dreq_sync rises two edges after dreq
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dreq_meta <= 1'b0;
      dreq_sync <= 1'b0;
    end else begin
      dreq_meta <= dreq;
      dreq_sync <= dreq_meta;
    end
  end

  // state flops
  // illegal codes still load as-is, the input plane steers them home
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= scsi_sm_pkg::reset_state;
    end else begin
      state <= scsi_sm_pkg::scsi_state_e'(next_state);
    end
  end

endmodule

`default_nettype wire

//--- scsi_sm/scsi_sm_inputs.sv
`timescale 1ns/100ps
`default_nettype none

module scsi_sm_inputs (
  input  scsi_sm_pkg::scsi_state_e               state,
  input  logic                                   cpureq,
  input  logic                                   rw,        // 1 = cpu reads chip
  input  logic                                   dreq_sync,
  input  logic                                   dmadir,    // 1 = chip to memory
  input  logic                                   fifofull,
  input  logic                                   fifoempty,
  input  logic                                   boeq3,
  output logic [scsi_sm_pkg::num_terms-1:0]      e_n        // active low terms
);

  // one-hot state match lines
  logic st_idle;
  logic st_cpu_sel;
  logic st_cpu_ack;
  logic st_cpu_wait;
  logic st_rd_scsi;
  logic st_rd_latch;
  logic st_wr_scsi;
  logic st_wr_done;
  logic st_illegal;

  // start conditions out of idle
  logic go_rd;
  logic go_wr;

  assign st_idle     = (state == scsi_sm_pkg::s_idle);
  assign st_cpu_sel  = (state == scsi_sm_pkg::s_cpu_sel);
  assign st_cpu_ack  = (state == scsi_sm_pkg::s_cpu_ack);
  assign st_cpu_wait = (state == scsi_sm_pkg::s_cpu_wait);
  assign st_rd_scsi  = (state == scsi_sm_pkg::s_rd_scsi);
  assign st_rd_latch = (state == scsi_sm_pkg::s_rd_latch);
  assign st_wr_scsi  = (state == scsi_sm_pkg::s_wr_scsi);
  assign st_wr_done  = (state == scsi_sm_pkg::s_wr_done);

  // nothing matched, code is outside the enum
  assign st_illegal = ~(st_idle | st_cpu_sel | st_cpu_ack | st_cpu_wait |
                        st_rd_scsi | st_rd_latch | st_wr_scsi | st_wr_done);

  // cpureq has priority over dma
  // back-pressure only blocks the start, never a running transfer
  assign go_rd = ~cpureq & dreq_sync & dmadir & ~fifofull;
  assign go_wr = ~cpureq & dreq_sync & ~dmadir & ~fifoempty;

  // idle
  assign e_n[scsi_sm_pkg::t_idle_cpu]  = ~(st_idle & cpureq);
  assign e_n[scsi_sm_pkg::t_idle_rd]   = ~(st_idle & go_rd);
  assign e_n[scsi_sm_pkg::t_idle_wr]   = ~(st_idle & go_wr);
  assign e_n[scsi_sm_pkg::t_idle_stay] = ~(st_idle & ~cpureq & ~go_rd & ~go_wr);

  // cpu select, direction from rw
  assign e_n[scsi_sm_pkg::t_sel_wr] = ~(st_cpu_sel & ~rw);
  assign e_n[scsi_sm_pkg::t_sel_rd] = ~(st_cpu_sel & rw);

  // cpu ack cycle
  assign e_n[scsi_sm_pkg::t_ack_wr] = ~(st_cpu_ack & ~rw);
  assign e_n[scsi_sm_pkg::t_ack_rd] = ~(st_cpu_ack & rw);

  // cpu wait, held while the host keeps cpureq up
  assign e_n[scsi_sm_pkg::t_wait_hold_wr] = ~(st_cpu_wait & cpureq & ~rw);
  assign e_n[scsi_sm_pkg::t_wait_hold_rd] = ~(st_cpu_wait & cpureq & rw);
  assign e_n[scsi_sm_pkg::t_wait_end]     = ~(st_cpu_wait & ~cpureq);

  // chip to fifo
  assign e_n[scsi_sm_pkg::t_rd_scsi]     = ~st_rd_scsi;
  assign e_n[scsi_sm_pkg::t_rd_latch]    = ~st_rd_latch;
  assign e_n[scsi_sm_pkg::t_rd_latch_b3] = ~(st_rd_latch & boeq3); // word full

  // fifo to chip
  assign e_n[scsi_sm_pkg::t_wr_scsi]    = ~st_wr_scsi;
  assign e_n[scsi_sm_pkg::t_wr_done]    = ~st_wr_done;
  assign e_n[scsi_sm_pkg::t_wr_done_b3] = ~(st_wr_done & boeq3); // word drained

  // recovery path back to idle
  assign e_n[scsi_sm_pkg::t_illegal] = ~st_illegal;

endmodule

`default_nettype wire

//--- scsi_sm/scsi_sm_outputs.sv
`timescale 1ns/100ps
`default_nettype none

module scsi_sm_outputs (
  input  logic [scsi_sm_pkg::num_terms-1:0]   e_n,
  output logic                                dack,
  output logic                                incbo,
  output logic                                incni,
  output logic                                incno,
  output logic                                re,
  output logic                                we,
  output logic                                scsi_cs,
  output logic                                set_dsack,
  output logic                                s2f,
  output logic                                f2s,
  output logic                                s2cpu,
  output logic                                cpu2s,
  output logic [scsi_sm_pkg::state_w-1:0]     next_state
);

  // named terms, all active low
  logic e_idle_cpu, e_idle_rd, e_idle_wr, e_idle_stay;
  logic e_sel_wr, e_sel_rd, e_ack_wr, e_ack_rd;
  logic e_hold_wr, e_hold_rd, e_wait_end;
  logic e_rd_scsi, e_rd_latch, e_rd_latch_b3;
  logic e_wr_scsi, e_wr_done, e_wr_done_b3;
  logic e_illegal;
  logic go_idle; // any term heading back to s_idle

  assign e_idle_cpu    = e_n[scsi_sm_pkg::t_idle_cpu];
  assign e_idle_rd     = e_n[scsi_sm_pkg::t_idle_rd];
  assign e_idle_wr     = e_n[scsi_sm_pkg::t_idle_wr];
  assign e_idle_stay   = e_n[scsi_sm_pkg::t_idle_stay];
  assign e_sel_wr      = e_n[scsi_sm_pkg::t_sel_wr];
  assign e_sel_rd      = e_n[scsi_sm_pkg::t_sel_rd];
  assign e_ack_wr      = e_n[scsi_sm_pkg::t_ack_wr];
  assign e_ack_rd      = e_n[scsi_sm_pkg::t_ack_rd];
  assign e_hold_wr     = e_n[scsi_sm_pkg::t_wait_hold_wr];
  assign e_hold_rd     = e_n[scsi_sm_pkg::t_wait_hold_rd];
  assign e_wait_end    = e_n[scsi_sm_pkg::t_wait_end];
  assign e_rd_scsi     = e_n[scsi_sm_pkg::t_rd_scsi];
  assign e_rd_latch    = e_n[scsi_sm_pkg::t_rd_latch];
  assign e_rd_latch_b3 = e_n[scsi_sm_pkg::t_rd_latch_b3];
  assign e_wr_scsi     = e_n[scsi_sm_pkg::t_wr_scsi];
  assign e_wr_done     = e_n[scsi_sm_pkg::t_wr_done];
  assign e_wr_done_b3  = e_n[scsi_sm_pkg::t_wr_done_b3];
  assign e_illegal     = e_n[scsi_sm_pkg::t_illegal];

  // next state, one nand per flop
  // bit 0 is built inverted from the idle-bound terms
  assign go_idle = ~(e_rd_latch & e_wr_done & e_illegal & e_idle_stay & e_wait_end);
  assign next_state[0] = ~go_idle;
  assign next_state[1] = ~(e_idle_cpu & e_ack_wr & e_ack_rd & e_hold_wr & e_hold_rd &
                           e_rd_scsi & e_wr_scsi); // sel, wait, latch, done
  assign next_state[2] = ~(e_sel_wr & e_sel_rd & e_ack_wr & e_ack_rd &
                           e_hold_wr & e_hold_rd); // ack, wait
  assign next_state[3] = ~(e_idle_rd & e_rd_scsi); // rd_scsi, rd_latch
  assign next_state[4] = ~(e_idle_wr & e_wr_scsi); // wr_scsi, wr_done

  // strobes
  assign dack      = ~(e_rd_scsi & e_wr_scsi);
  assign re        = ~e_rd_scsi;
  assign we        = ~e_wr_scsi;
  assign s2f       = ~(e_rd_scsi & e_rd_latch);
  assign f2s       = ~(e_wr_scsi & e_wr_done);
  assign incbo     = ~(e_rd_latch & e_wr_done); // one byte per transfer
  assign incni     = ~e_rd_latch_b3;            // fifo in pointer
  assign incno     = ~e_wr_done_b3;             // fifo out pointer
  assign scsi_cs   = ~(e_sel_wr & e_sel_rd & e_ack_wr & e_ack_rd & e_hold_wr & e_hold_rd);
  assign set_dsack = ~(e_ack_wr & e_ack_rd);
  assign s2cpu     = ~(e_sel_rd & e_ack_rd & e_hold_rd);
  assign cpu2s     = ~(e_sel_wr & e_ack_wr & e_hold_wr);

endmodule

`default_nettype wire

//--- scsi_sm/scsi_sm.sv
`timescale 1ns/100ps
`default_nettype none

module scsi_sm (
  input  logic clk,
  input  logic arst_n,
  // conditions
  input  logic cpureq,    // host wants a chip register
  input  logic rw,        // 1 = read from chip
  input  logic dreq,      // chip dma request, async
  input  logic dmadir,    // 1 = chip to memory
  input  logic fifofull,
  input  logic fifoempty,
  input  logic boeq3,     // byte pointer at last byte
  // strobes
  output logic dack,
  output logic re,
  output logic we,
  output logic scsi_cs,
  output logic set_dsack,
  output logic s2f,
  output logic f2s,
  output logic s2cpu,
  output logic cpu2s,
  output logic incbo,
  output logic incni,
  output logic incno
);

  logic [scsi_sm_pkg::num_terms-1:0] e_n;        // and plane to nand plane
  logic [scsi_sm_pkg::state_w-1:0]   next_state;
  scsi_sm_pkg::scsi_state_e          state;
  logic                              dreq_sync;

  scsi_sm_state state_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .dreq       (dreq),
    .next_state (next_state),
    .state      (state),
    .dreq_sync  (dreq_sync)
  );

  scsi_sm_inputs inputs_i (
    .state     (state),
    .cpureq    (cpureq),
    .rw        (rw),
    .dreq_sync (dreq_sync),
    .dmadir    (dmadir),
    .fifofull  (fifofull),
    .fifoempty (fifoempty),
    .boeq3     (boeq3),
    .e_n       (e_n)
  );

  scsi_sm_outputs outputs_i (
    .e_n        (e_n),
    .dack       (dack),
    .incbo      (incbo),
    .incni      (incni),
    .incno      (incno),
    .re         (re),
    .we         (we),
    .scsi_cs    (scsi_cs),
    .set_dsack  (set_dsack),
    .s2f        (s2f),
    .f2s        (f2s),
    .s2cpu      (s2cpu),
    .cpu2s      (cpu2s),
    .next_state (next_state)
  );

endmodule

`default_nettype wire

//--- testbench/scsi_sm_chk.sv
`timescale 1ns/100ps
`default_nettype none

module scsi_sm_chk (
  input logic clk,
  input logic arst_n,
  input logic dack,
  input logic re,
  input logic we,
  input logic scsi_cs,
  input logic set_dsack,
  input logic s2f,
  input logic f2s
);

  // fifo data path runs one way at a time
  a_s2f_f2s: assert property (@(posedge clk) disable iff (!arst_n)
    !(s2f && f2s))
    else $error("s2f and f2s high in the same cycle");

  // a dma cycle is either a read or a write of the chip
  a_dack_dir: assert property (@(posedge clk) disable iff (!arst_n)
    dack |-> (re ^ we))
    else $error("dack without exactly one of re and we");

  a_cs_dack: assert property (@(posedge clk) disable iff (!arst_n)
    !(scsi_cs && dack)) // cpu and dma never share the chip
    else $error("scsi_cs and dack high in the same cycle");

  a_dsack_cs: assert property (@(posedge clk) disable iff (!arst_n)
    set_dsack |-> scsi_cs)
    else $error("set_dsack outside a chip select");

endmodule

`default_nettype wire

//--- testbench/tb_scsi_sm.sv
`timescale 1ns/100ps
`default_nettype none

module tb_scsi_sm;

  logic clk;
  logic arst_n;

  // condition inputs
  logic cpureq;
  logic rw;
  logic dreq;
  logic dmadir;
  logic fifofull;
  logic fifoempty;
  logic boeq3;

  // strobes from the DUT
  logic dack;
  logic re;
  logic we;
  logic scsi_cs;
  logic set_dsack;
  logic s2f;
  logic f2s;
  logic s2cpu;
  logic cpu2s;
  logic incbo;
  logic incni;
  logic incno;

  logic [19:0] vec_mem [0:255]; // {end flag, 7 inputs, 12 expected outputs}
  int          vec_count;
  int          cur_vec;         // line being played, shown in error lines
  int          err_count;
  bit          vec_loaded;      // releases the watchdog

  scsi_sm scsi_sm_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .cpureq    (cpureq),
    .rw        (rw),
    .dreq      (dreq),
    .dmadir    (dmadir),
    .fifofull  (fifofull),
    .fifoempty (fifoempty),
    .boeq3     (boeq3),
    .dack      (dack),
    .re        (re),
    .we        (we),
    .scsi_cs   (scsi_cs),
    .set_dsack (set_dsack),
    .s2f       (s2f),
    .f2s       (f2s),
    .s2cpu     (s2cpu),
    .cpu2s     (cpu2s),
    .incbo     (incbo),
    .incni     (incni),
    .incno     (incno)
  );

  // strobe exclusivity checks on the DUT
  bind scsi_sm scsi_sm_chk chk_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .dack      (dack),
    .re        (re),
    .we        (we),
    .scsi_cs   (scsi_cs),
    .set_dsack (set_dsack),
    .s2f       (s2f),
    .f2s       (f2s)
  );

  always #2 clk = ~clk; // 4 ns period

  task automatic check_val(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("ERR %0.1f ns vector %0d %s expected %b got %b",
               $realtime, cur_vec, name, expected, actual);
      err_count++;
    end
  endtask

  // bit order matches the vectors file
  task automatic drive_inputs(input logic [6:0] in_bits);
    {cpureq, rw, dreq, dmadir, fifofull, fifoempty, boeq3} = in_bits;
  endtask

  task automatic check_outputs(input logic [11:0] exp);
    check_val("dack", exp[11], dack);
    check_val("re", exp[10], re);
    check_val("we", exp[9], we);
    check_val("scsi_cs", exp[8], scsi_cs);
    check_val("set_dsack", exp[7], set_dsack);
    check_val("s2f", exp[6], s2f);
    check_val("f2s", exp[5], f2s);
    check_val("s2cpu", exp[4], s2cpu);
    check_val("cpu2s", exp[3], cpu2s);
    check_val("incbo", exp[2], incbo);
    check_val("incni", exp[1], incni);
    check_val("incno", exp[0], incno);
  endtask

  // lines before the end flag, -1 when the flag is missing
  function automatic int count_vectors();
    for (int i = 0; i < 256; i++) begin
      if (vec_mem[i][19] === 1'b1) begin
        return i;
      end
    end
    return -1;
  endfunction

  // reset held over the first three rising edges
  initial begin
    clk    = 1'b0;
    arst_n = 1'b0;
    repeat (3) @(posedge clk);
    #0.5 arst_n = 1'b1;
  end

  // run limit scales with the vector count
  initial begin : watchdog
    wait (vec_loaded);
    #((vec_count + 20) * 4);
    $display("timeout: vector playback did not finish within %0d ns",
             (vec_count + 20) * 4);
    $display("sim failed");
    $finish;
  end

  initial begin : playback
    int n;
    drive_inputs(7'b0);
    err_count  = 0;
    cur_vec    = 0;
    vec_count  = 0;
    vec_loaded = 1'b0;
    $readmemh("testbench/scsi_sm_vectors.txt", vec_mem);
    n = count_vectors();
    if (n <= 0) begin
      $display("vector file holds no vectors or lacks its end line");
      err_count++;
    end else begin
      vec_count = n;
    end
    vec_loaded = 1'b1;
    // one line per clock, inputs after the edge, outputs just before the next
    for (int i = 0; i < vec_count; i++) begin
      cur_vec = i;
      @(posedge clk);
      #0.5;
      drive_inputs(vec_mem[i][18:12]);
      #3;
      check_outputs(vec_mem[i][11:0]);
    end
    $display("%0d vectors played, %0d errors", vec_count, err_count);
    if (err_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/scsi_sm_vectors.txt
// digits: {end cpureq rw dreq} {dmadir fifofull fifoempty boeq3} {dack re we scsi_cs}
//         {set_dsack s2f f2s s2cpu} {cpu2s incbo incni incno}, first digit 8 ends the list
// reset and idle
00000
00000
00000
00000 // first cycle out of reset
00000
00000
// cpu read of the chip
60000 // cpureq seen in idle
60110 // select
60190 // ack with set_dsack
60110 // wait
60110
20000 // cpureq dropped
00000
// cpu write of the chip
40000
40108
40188
40108
00000
00000
// chip to fifo, boeq3 low
18000 // dreq pulse
08000
08000 // synced dreq in idle
08C40 // dack re s2f
08044 // s2f incbo
08000
// chip to fifo, boeq3 high
19000
09000
09000
09C40
09046 // incni on the last byte
00000
// fifo to chip, boeq3 high
11000
01000
01000
01A20 // dack we f2s
01025 // f2s incbo incno
00000
// read dreq held off by fifofull
1C000
1C000
1C000 // synced, still idle
1C000
18000 // fifofull clears
0CC40 // started transfer runs on
0C044
08000
08000
// write dreq held off by fifoempty
12000
12000
12000
10000 // fifoempty clears
02A20
02024
00000
// cpureq with dreq, cpu first
78000
78110
78190
78110
18000 // cpu done
08000 // dma starts
08C40
08044
00000
// cpureq meets synced dreq in idle
10000
10000
50000 // cpureq wins
10108
10188
10000
00000 // write dma follows
00A20
00024
00000
00000
80000

//--- all.f
common/scsi_sm_pkg.sv
scsi_sm/scsi_sm_state.sv
scsi_sm/scsi_sm_inputs.sv
scsi_sm/scsi_sm_outputs.sv
scsi_sm/scsi_sm.sv
testbench/scsi_sm_chk.sv
testbench/tb_scsi_sm.sv

//--- run_sim.sh
#!/usr/bin/env bash
# verilator build and run of the scsi_sm testbench
set -e

cd "$(dirname "$0")"

log=sim.log

verilator --binary --assert --timescale 1ns/100ps -j 0 \
  --top-module tb_scsi_sm -f all.f

./obj_dir/Vtb_scsi_sm > "$log" 2>&1 || true
cat "$log"

# the log must hold the pass line
if grep -qx "sim passed" "$log"; then
  exit 0
fi

echo "simulation did not pass, see $log"
exit 1
